// File: src/boot_mem_defines.svh
/*
  Global sizes for the boot and data memory block.
  DM_DEPTH_BITS + 2 must not exceed ADDR_BITS, since the memory is
  indexed by byte address bits [DM_DEPTH_BITS+1:2].
  LINE_BITS must equal SEG_WORDS * WORD_BITS.
*/
`ifndef BOOT_MEM_DEFINES_SVH
`define BOOT_MEM_DEFINES_SVH

// data path
`define WORD_BITS      32
`define ADDR_BITS      16

// host request address with the upper bits always zero
`define EX_ADDR_BITS   64

// boot image layout
`define SEG_COUNT      4
`define SEG_WORDS      16

// one accelerator line is SEG_WORDS words
`define LINE_BITS      512

// 16K words of data memory
`define DM_DEPTH_BITS  14

`endif

// File: src/mem_types_pkg.sv
/*
  Types shared by everything that touches the data memory.
  A mem_wr_t with valid low is ignored by the memory, whatever
  its address and data hold.
*/
`include "boot_mem_defines.svh"

package mem_types_pkg;

    typedef logic [`WORD_BITS-1:0]     word_t;
    typedef logic [`ADDR_BITS-1:0]     byte_addr_t;
    typedef logic [`DM_DEPTH_BITS-1:0] word_idx_t;   // byte address / 4
    typedef logic [`LINE_BITS-1:0]     line_t;       // word k at bits 32k up

    ////////////////////////////////////////////////////////////////////
    // single word write request
    ////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic       valid;
        byte_addr_t addr;   // word aligned
        word_t      data;
    } mem_wr_t;

endpackage

// File: src/host_types_pkg.sv
/*
  Types for the host side of the boot path.
  Only IDLE and READ are issued; this block never writes to the host.
  SEG_BASE holds SEG_COUNT word-aligned bases, loaded in table order.
*/
`include "boot_mem_defines.svh"

package host_types_pkg;

    // request opcode on the external port
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        READ = 2'b01
    } host_op_t;

    // boot sequencer states
    typedef enum logic [2:0] {
        WAIT_READY = 3'd0,
        REQ_SEG    = 3'd1,
        LOAD_SEG   = 3'd2,
        RUN        = 3'd3
    } loader_state_t;

    typedef logic [`EX_ADDR_BITS-1:0] ex_addr_t;

    ////////////////////////////////////////////////////////////////////
    // data segment bases in load order
    ////////////////////////////////////////////////////////////////////
    localparam logic [`ADDR_BITS-1:0] SEG_BASE [`SEG_COUNT] = '{
        16'h1000,
        16'h1040,
        16'h2000,
        16'h0100
    };

endpackage

// File: src/segment_loader.sv
/*
  Boot sequencer. Waits for ready, then pulls SEG_COUNT segments from
  the host and writes every word into data memory.
  The host must frame each segment with rd_valid on word 0 and tx_done
  on the last word, with one word per cycle in between. There is no
  flow control toward the host. After the last segment the block sits
  in RUN until reset.
*/
`timescale 1ns/10ps
`include "boot_mem_defines.svh"

module segment_loader
    import mem_types_pkg::*;
    import host_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ready,
    input  logic     rd_valid,
    input  logic     tx_done,
    input  word_t    ex_wrt_data,
    output host_op_t op,
    output ex_addr_t ex_addr,
    output mem_wr_t  load_wr,
    output logic     load_done
);

    localparam int unsigned SEG_CNT_BITS = $clog2(`SEG_COUNT);
    localparam int unsigned EX_PAD       = `EX_ADDR_BITS - `ADDR_BITS;

    loader_state_t           state;
    loader_state_t           next_state;
    logic [SEG_CNT_BITS-1:0] seg_cnt;
    byte_addr_t              cur_addr;   // address of the next word
    logic                    set_addr;
    logic                    step_addr;
    logic                    seg_end;
    logic                    last_seg;

    assign last_seg  = (seg_cnt == SEG_CNT_BITS'(`SEG_COUNT - 1));
    assign seg_end   = (state == LOAD_SEG) && tx_done;
    assign load_done = (state == RUN);

    //////////////////////////////////////////////////////////////////////
    // state, segment counter, write address
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= WAIT_READY;
            seg_cnt  <= '0;
            cur_addr <= '0;
        end else begin
            state <= next_state;
            if (seg_end && !last_seg)
                seg_cnt <= seg_cnt + 1'b1;
            if (set_addr)
                cur_addr <= SEG_BASE[seg_cnt] + byte_addr_t'(4);  // word 0 goes to base
            else if (step_addr)
                cur_addr <= cur_addr + byte_addr_t'(4);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state and host / memory outputs
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        next_state = state;
        op         = IDLE;
        ex_addr    = '0;
        load_wr    = '0;
        set_addr   = 1'b0;
        step_addr  = 1'b0;

        case (state)
            WAIT_READY: begin
                if (ready)
                    next_state = REQ_SEG;
            end
            REQ_SEG: begin
                op       = READ;
                ex_addr  = {{EX_PAD{1'b0}}, SEG_BASE[seg_cnt]};
                set_addr = 1'b1;
                if (rd_valid) begin
                    // first word lands at the base itself
                    load_wr    = '{valid: 1'b1, addr: SEG_BASE[seg_cnt], data: ex_wrt_data};
                    next_state = LOAD_SEG;
                end
            end
            LOAD_SEG: begin
                op        = READ;
                load_wr   = '{valid: 1'b1, addr: cur_addr, data: ex_wrt_data};
                step_addr = 1'b1;
                if (tx_done)
                    next_state = last_seg ? RUN : REQ_SEG;  // tx_done word is still written
            end
            RUN: begin
                next_state = RUN;
            end
            default: begin
                next_state = WAIT_READY;
            end
        endcase
    end

    // boot runs once; after load_done the host port stays quiet
    a_run_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        load_done |=> (load_done && op != READ))
        else $error("loader left RUN or requested host data after boot");

endmodule

// File: src/data_mem.sv
/*
  Word-wide data memory, one write port shared by the loader and the
  accelerator, and one registered read port.
  A loader write always wins. An accelerator write in the same cycle
  is dropped and gets no done pulse. Writes use address bits
  [DM_DEPTH_BITS+1:2], so addresses must be word aligned.
*/
`timescale 1ns/10ps
`include "boot_mem_defines.svh"

module data_mem
    import mem_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  mem_wr_t   load_wr,
    input  mem_wr_t   accel_wr,
    input  word_idx_t rd_idx,
    output word_t     rd_data,
    output logic      accel_wrt_done
);

    localparam int unsigned IDX_LSB = 2;
    localparam int unsigned IDX_TOP = `DM_DEPTH_BITS + IDX_LSB;
    localparam int unsigned DEPTH   = 1 << `DM_DEPTH_BITS;

    word_t     mem [DEPTH];
    mem_wr_t   wr;           // winning request
    word_idx_t wr_idx;
    logic      accel_take;

    //////////////////////////////////////////////////////////////////////
    // write arbitration
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        accel_take = accel_wr.valid && !load_wr.valid;
        wr         = load_wr.valid ? load_wr : accel_wr;
        wr_idx     = wr.addr[IDX_TOP-1:IDX_LSB];
    end

    // array write and registered read
    always_ff @(posedge clk) begin
        if (wr.valid)
            mem[wr_idx] <= wr.data;
        rd_data <= mem[rd_idx];   // one cycle read latency
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            accel_wrt_done <= 1'b0;
        else
            accel_wrt_done <= accel_take;   // pulse only for an accepted write
    end

    // requests from loader and top must be aligned and inside the array
    a_wr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        wr.valid |-> ((wr.addr >> IDX_TOP) == '0 && wr.addr[IDX_LSB-1:0] == '0))
        else $error("write address 0x%0h outside data memory", wr.addr);

endmodule

// File: src/line_reader.sv
/*
  Reads one aligned 64-byte line as SEG_WORDS sequential word reads.
  accel_addr must be 64-byte aligned. The first read is issued in the
  request cycle, so accel_rd_valid comes 17 cycles after accel_rd_en.
  accel_rd_en is ignored while accel_busy is high. The line stays on
  accel_rd_data until the next read.
*/
`timescale 1ns/10ps
`include "boot_mem_defines.svh"

module line_reader
    import mem_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       accel_rd_en,
    input  byte_addr_t accel_addr,
    input  word_t      rd_data,
    output word_idx_t  rd_idx,
    output line_t      accel_rd_data,
    output logic       accel_rd_valid,
    output logic       accel_busy
);

    localparam int unsigned IDX_LSB  = 2;
    localparam int unsigned IDX_TOP  = `DM_DEPTH_BITS + IDX_LSB;
    localparam int unsigned CNT_BITS = $clog2(`SEG_WORDS);
    localparam int unsigned LINE_LSB = CNT_BITS + IDX_LSB;   // 64-byte line

    byte_addr_t          base_addr;
    logic [CNT_BITS-1:0] cnt;        // words captured so far
    logic                accept;
    logic                last_word;
    line_t               line_q;

    assign accept        = accel_rd_en && !accel_busy;
    assign last_word     = (cnt == CNT_BITS'(`SEG_WORDS - 1));
    assign accel_rd_data = line_q;

    // word 0 straight from the request, the rest from the latched base
    always_comb begin
        if (accel_busy)
            rd_idx = base_addr[IDX_TOP-1:IDX_LSB] + word_idx_t'(cnt) + word_idx_t'(1);
        else
            rd_idx = accel_addr[IDX_TOP-1:IDX_LSB];
    end

    //////////////////////////////////////////////////////////////////////
    // sequencing
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accel_busy     <= 1'b0;
            accel_rd_valid <= 1'b0;
            cnt            <= '0;
        end else if (accel_rd_valid) begin
            accel_busy     <= 1'b0;   // busy ends with the valid cycle
            accel_rd_valid <= 1'b0;
        end else if (accel_busy) begin
            cnt            <= cnt + 1'b1;   // wraps back to 0 after the last word
            accel_rd_valid <= last_word;
        end else if (accept) begin
            accel_busy <= 1'b1;
        end
    end

    // oldest word of the line ends up in the low bits
    always_ff @(posedge clk) begin
        if (accept)
            base_addr <= accel_addr;
        if (accel_busy && !accel_rd_valid)
            line_q <= {rd_data, line_q[`LINE_BITS-1:`WORD_BITS]};
    end

    a_line_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> (base_addr[LINE_LSB-1:0] == '0))
        else $error("line read address 0x%0h not 64-byte aligned", base_addr);

endmodule

// File: src/boot_mem_top.sv
/*
  Boot loader, data memory and accelerator line port.
  Host words are paced by the host with no back-pressure. An accelerator
  write that collides with a loader write is lost without a done pulse.
*/
`timescale 1ns/10ps

module boot_mem_top
    import mem_types_pkg::*;
    import host_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // host side
    input  logic       ready,
    input  logic       rd_valid,
    input  logic       tx_done,
    input  word_t      ex_wrt_data,
    output host_op_t   op,
    output ex_addr_t   ex_addr,
    output logic       load_done,
    // accelerator side
    input  byte_addr_t accel_addr,
    input  word_t      accel_wrt_data,
    input  logic       accel_wrt_en,
    input  logic       accel_rd_en,
    output logic       accel_wrt_done,
    output line_t      accel_rd_data,
    output logic       accel_rd_valid,
    output logic       accel_busy
);

    mem_wr_t   load_wr;
    mem_wr_t   accel_wr;
    word_idx_t rd_idx;
    word_t     rd_data;

    assign accel_wr = '{valid: accel_wrt_en, addr: accel_addr, data: accel_wrt_data};

    segment_loader u_loader (
        .clk(clk), .rst_n(rst_n), .ready(ready), .rd_valid(rd_valid), .tx_done(tx_done),
        .ex_wrt_data(ex_wrt_data), .op(op), .ex_addr(ex_addr), .load_wr(load_wr),
        .load_done(load_done)
    );

    data_mem u_mem (
        .clk(clk), .rst_n(rst_n), .load_wr(load_wr), .accel_wr(accel_wr),
        .rd_idx(rd_idx), .rd_data(rd_data), .accel_wrt_done(accel_wrt_done)
    );

    line_reader u_line (
        .clk(clk), .rst_n(rst_n), .accel_rd_en(accel_rd_en), .accel_addr(accel_addr),
        .rd_data(rd_data), .rd_idx(rd_idx), .accel_rd_data(accel_rd_data),
        .accel_rd_valid(accel_rd_valid), .accel_busy(accel_busy)
    );

endmodule

// File: bench/tb_clock.sv
/*
  Free-running testbench clock, starts low.
  PERIOD_NS must be even.
*/
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// File: bench/boot_mem_tb.sv
/*
  Testbench for boot_mem_top, acting as host and accelerator.
  Commands come from bench/boot_mem_patterns.txt, three hex fields each.
  Segment commands must come first, one per boot segment, in table order.
  Inputs change 2 ns after the rising edge, outputs are read on the
  falling edge. Line reads may only cover words written before.
*/
`timescale 1ns/10ps
`include "boot_mem_defines.svh"

module boot_mem_tb
    import mem_types_pkg::*;
    import host_types_pkg::*;
();

    localparam int TIMEOUT = 200;
    localparam logic [`ADDR_BITS-1:0] BASES [`SEG_COUNT] = '{
        16'h1000, 16'h1040, 16'h2000, 16'h0100
    };

    logic       clk;
    logic       rst_n;
    logic       ready;
    logic       rd_valid;
    logic       tx_done;
    word_t      ex_wrt_data;
    host_op_t   op;
    ex_addr_t   ex_addr;
    logic       load_done;
    byte_addr_t accel_addr;
    word_t      accel_wrt_data;
    logic       accel_wrt_en;
    logic       accel_rd_en;
    logic       accel_wrt_done;
    line_t      accel_rd_data;
    logic       accel_rd_valid;
    logic       accel_busy;

    word_t pat [256];        // cmd, a, b triples
    word_t ref_mem [int];    // expected contents by word index
    int    errors;
    int    seg_idx;

    tb_clock #(.PERIOD_NS(40)) u_clk (.clk(clk));

    boot_mem_top u_dut (.*);

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////
    task automatic check(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    //////////////////////////////////////////////////////////////////////
    // host side, one boot segment
    //////////////////////////////////////////////////////////////////////
    task automatic load_segment(input word_t first, input word_t step);
        int    gap;
        int    waited;
        word_t data;
        if (seg_idx >= `SEG_COUNT)
            abort_run("pattern file holds more segments than the boot table");
        waited = 0;
        @(negedge clk);
        while (op != READ) begin
            check("op", line_t'(op), line_t'(IDLE));
            waited++;
            if (waited > TIMEOUT)
                abort_run("timeout waiting for the segment request");
            @(negedge clk);
        end
        check("ex_addr", line_t'(ex_addr), line_t'(BASES[seg_idx[1:0]]));
        gap = $urandom % 4;
        repeat (gap) begin   // host idles before word 0
            next_cycle();
            @(negedge clk);
            check("op", line_t'(op), line_t'(READ));
            check("ex_addr", line_t'(ex_addr), line_t'(BASES[seg_idx[1:0]]));
        end
        for (int k = 0; k < `SEG_WORDS; k++) begin
            next_cycle();
            data        = first + step * word_t'(k);
            rd_valid    = (k == 0);
            tx_done     = (k == `SEG_WORDS - 1);
            ex_wrt_data = data;
            ref_mem[int'(BASES[seg_idx[1:0]] >> 2) + k] = data;
        end
        @(negedge clk);
        check("load_done", line_t'(load_done), '0);
        next_cycle();
        rd_valid    = 1'b0;
        tx_done     = 1'b0;
        ex_wrt_data = '0;
        @(negedge clk);
        check("load_done", line_t'(load_done), line_t'(seg_idx == `SEG_COUNT - 1));
        seg_idx++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // accelerator side
    //////////////////////////////////////////////////////////////////////
    task automatic accel_write(input byte_addr_t addr, input word_t data);
        next_cycle();
        accel_addr     = addr;
        accel_wrt_data = data;
        accel_wrt_en   = 1'b1;
        ref_mem[int'(addr >> 2)] = data;
        @(negedge clk);
        check("accel_wrt_done", line_t'(accel_wrt_done), '0);
        next_cycle();
        accel_wrt_en = 1'b0;
        @(negedge clk);
        check("accel_wrt_done", line_t'(accel_wrt_done), line_t'(1'b1));
        next_cycle();
        @(negedge clk);
        check("accel_wrt_done", line_t'(accel_wrt_done), '0);   // one cycle only
    endtask

    task automatic line_read(input byte_addr_t addr);
        line_t exp_line;
        int    idx;
        int    cycles;
        idx = int'(addr >> 2);
        for (int k = 0; k < `SEG_WORDS; k++) begin
            if (!ref_mem.exists(idx + k))
                abort_run("line read covers a word that was never written");
            exp_line[k*`WORD_BITS +: `WORD_BITS] = ref_mem[idx + k];
        end
        next_cycle();
        accel_addr  = addr;
        accel_rd_en = 1'b1;
        cycles      = 0;
        @(negedge clk);
        check("accel_busy", line_t'(accel_busy), '0);
        do begin
            next_cycle();
            cycles++;
            accel_rd_en = (cycles == 3);   // second request while busy
            // points at another line, which must not be latched
            accel_addr  = (cycles == 3) ? (addr ^ byte_addr_t'(16'h0040)) : addr;
            @(negedge clk);
            if (cycles > TIMEOUT)
                abort_run("timeout waiting for accel_rd_valid");
            check("accel_busy", line_t'(accel_busy), line_t'(1'b1));
        end while (!accel_rd_valid);
        check("accel_rd_valid delay", line_t'(cycles), line_t'(17));
        check("accel_rd_data", accel_rd_data, exp_line);
        // an accepted second request would pulse valid again in here
        repeat (20) begin
            next_cycle();
            @(negedge clk);
            check("accel_rd_valid", line_t'(accel_rd_valid), '0);
            check("accel_busy", line_t'(accel_busy), '0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [7:0] p;
        word_t      cmd;
        rst_n          = 1'b0;
        ready          = 1'b0;
        rd_valid       = 1'b0;
        tx_done        = 1'b0;
        ex_wrt_data    = '0;
        accel_addr     = '0;
        accel_wrt_data = '0;
        accel_wrt_en   = 1'b0;
        accel_rd_en    = 1'b0;
        errors         = 0;
        seg_idx        = 0;
        void'($urandom(32'h5f258d74));
        $readmemh("bench/boot_mem_patterns.txt", pat);
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (8) begin   // ready still low, loader must stay quiet
            @(negedge clk);
            check("op", line_t'(op), line_t'(IDLE));
            check("ex_addr", line_t'(ex_addr), '0);
            check("load_done", line_t'(load_done), '0);
            check("accel_busy", line_t'(accel_busy), '0);
            check("accel_rd_valid", line_t'(accel_rd_valid), '0);
            check("accel_wrt_done", line_t'(accel_wrt_done), '0);
            next_cycle();
        end
        ready = 1'b1;
        p     = '0;
        cmd   = pat[p];
        while (cmd != 0) begin
            if (p > 8'd250)
                abort_run("pattern file has no end command");
            case (cmd)
                1: load_segment(pat[p + 8'd1], pat[p + 8'd2]);
                2: accel_write(byte_addr_t'(pat[p + 8'd1]), pat[p + 8'd2]);
                3: line_read(byte_addr_t'(pat[p + 8'd1]));
                default: abort_run("unknown command in pattern file");
            endcase
            p   = p + 8'd3;
            cmd = pat[p];
        end
        check("load_done", line_t'(load_done), line_t'(1'b1));
        check("op", line_t'(op), line_t'(IDLE));
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: boot_mem_top.f
+incdir+src
src/mem_types_pkg.sv
src/host_types_pkg.sv
src/segment_loader.sv
src/data_mem.sv
src/line_reader.sv
src/boot_mem_top.sv
bench/tb_clock.sv
bench/boot_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build boot_mem_tb with Verilator, run it, pass only if the pass line shows up
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module boot_mem_tb -f boot_mem_top.f

sim_out=$(./obj_dir/Vboot_mem_tb 2>&1 || true)
echo "$sim_out"
if echo "$sim_out" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
exit 1

// File: bench/boot_mem_patterns.txt
// columns: cmd a b, all hex
// cmd 1 segment (a word 0, b step), 2 accel write (a addr, b data), 3 line read (a addr), 0 end
// boot segments in table order
1 10000000 00000001
1 a5a50000 00010003
1 0badc0de 11111111
1 fffffff0 fffffffd
// lines as loaded
3 1000 0
3 1040 0
3 2000 0
3 0100 0
// single word writes into loaded lines
2 1008 deadbeef
2 107c 12345678
2 2030 cafef00d
2 0100 00c0ffee
2 2034 55aa55aa
// lines after the writes
3 1000 0
3 1040 0
3 2000 0
3 0100 0
0 0 0
